/* Makefile */
TOP := tb_timer_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f timer_subsystem.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* hw/cdc_handshake.sv */
`timescale 1ns/1ps
`default_nettype none

module cdc_handshake #(
    parameter type payload_t = logic
) (
    // Source domain
    input  wire           clk_src,
    input  wire           rst,
    input  wire payload_t in_data,
    input  wire           in_valid,
    output logic          busy,
    // Destination domain
    input  wire           clk_dst,
    output payload_t      out_data,
    output logic          out_valid
);

    payload_t   src_data;   // Held while crossing
    logic       req;
    logic [1:0] ack_sync;
    logic [1:0] req_sync;
    logic       req_q;      // Edge detect
    logic       ack;

    // Source side
    always_ff @(posedge clk_src or posedge rst) begin
        if (rst) begin
            req      <= 1'b0;
            busy     <= 1'b0;
            ack_sync <= 2'b00;
        end else begin
            ack_sync <= {ack_sync[0], ack};
            if (!busy) begin
                if (in_valid) begin
                    req  <= 1'b1;
                    busy <= 1'b1;
                end
            end else if (req) begin
                if (ack_sync[1]) req <= 1'b0;  // Ack arrived
            end else if (!ack_sync[1]) begin
                busy <= 1'b0;  // Ack released, round trip done
            end
        end
    end

    always_ff @(posedge clk_src) begin
        if (!busy && in_valid) src_data <= in_data;
    end

    // Destination side
    always_ff @(posedge clk_dst or posedge rst) begin
        if (rst) begin
            req_sync  <= 2'b00;
            req_q     <= 1'b0;
            ack       <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            req_sync  <= {req_sync[0], req};
            req_q     <= req_sync[1];
            out_valid <= req_sync[1] && !req_q;
            if (req_sync[1] && !req_q) begin
                ack <= 1'b1;
            end else if (!req_sync[1]) begin
                ack <= 1'b0;
            end
        end
    end

    // src_data has been stable for at least two clk_dst edges here
    always_ff @(posedge clk_dst) begin
        if (req_sync[1] && !req_q) out_data <= src_data;
    end

    a_req_held: assert property (@(posedge clk_src) disable iff (rst)
        req && !ack_sync[1] |=> req)
        else $error("req dropped before ack was seen");

    a_payload_stable: assert property (@(posedge clk_src) disable iff (rst)
        req |=> $stable(src_data))
        else $error("payload changed during crossing");

    a_valid_pulse: assert property (@(posedge clk_dst) disable iff (rst)
        out_valid |=> !out_valid)
        else $error("out_valid high for two cycles");

endmodule

`default_nettype wire

/* hw/timer_bus_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module timer_bus_fsm import timer_pkg::*; (
    input  wire             clk_bus,
    input  wire             rst,
    input  wire bus_req_t   bus_req,
    output bus_rsp_t        bus_rsp,
    output timer_cmd_t      cmd,
    output logic            cmd_valid,
    input  wire             cmd_busy,
    input  wire word_t      snap_data,
    input  wire             snap_valid
);

    typedef enum logic [1:0] {
        st_idle,
        st_send,
        st_wait
    } state_t;

    state_t state;
    word_t  snapshot;
    word_t  cycle_count;
    logic   accept;

    assign accept    = bus_req.write && (state == st_idle);
    assign cmd_valid = (state == st_send);  // One cycle per write

    always_ff @(posedge clk_bus or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) state <= st_send;
                end
                st_send: begin
                    state <= st_wait;  // Handshake captures cmd here
                end
                st_wait: begin
                    if (!cmd_busy) state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Command payload latched on acceptance
    always_ff @(posedge clk_bus) begin
        if (accept) begin
            if (bus_req.address == ADDR_TIMER) begin
                cmd.kind <= cmd_load_timer;
            end else begin
                cmd.kind <= cmd_set_divisor;
            end
            cmd.value <= bus_req.data_wr;
        end
    end

    always_ff @(posedge clk_bus or posedge rst) begin
        if (rst) begin
            snapshot <= '0;
        end else if (snap_valid) begin
            snapshot <= snap_data;
        end
    end

    always_ff @(posedge clk_bus or posedge rst) begin
        if (rst) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 32'd1;
        end
    end

    always_comb begin
        bus_rsp.stall = (state != st_idle);
        if (!bus_req.read) begin
            bus_rsp.data_rd = '0;
        end else if (bus_req.address == ADDR_TIMER) begin
            bus_rsp.data_rd = snapshot;
        end else begin
            bus_rsp.data_rd = cycle_count;
        end
    end

    // A command only follows a write seen with stall low
    a_no_write_in_stall: assert property (@(posedge clk_bus) disable iff (rst)
        state == st_send |-> $past(bus_req.write && !bus_rsp.stall))
        else $error("write accepted while stall was high");

endmodule

`default_nettype wire

/* hw/timer_core.sv */
`timescale 1ns/1ps
`default_nettype none

module timer_core import timer_pkg::*; (
    input  wire              clk_10M,
    input  wire              rst,
    input  wire timer_cmd_t  cmd,
    input  wire              cmd_valid,
    output word_t            timer_value
);

    div_t divisor;
    div_t prescaler;
    logic wrap;

    // Prescaler at the divisor ends a tick
    assign wrap = (prescaler >= divisor);

    always_ff @(posedge clk_10M or posedge rst) begin
        if (rst) begin
            divisor <= DIV_RESET;
        end else if (cmd_valid && cmd.kind == cmd_set_divisor) begin
            divisor <= cmd.value[15:0];
        end
    end

    always_ff @(posedge clk_10M or posedge rst) begin
        if (rst) begin
            prescaler <= '0;
        end else if (cmd_valid || wrap) begin
            prescaler <= '0;  // Any command restarts the tick
        end else begin
            prescaler <= prescaler + 16'd1;
        end
    end

    always_ff @(posedge clk_10M or posedge rst) begin
        if (rst) begin
            timer_value <= '0;
        end else if (cmd_valid && cmd.kind == cmd_load_timer) begin
            timer_value <= cmd.value;
        end else if (!cmd_valid && wrap) begin
            timer_value <= timer_value + 32'd1;
        end
    end

endmodule

`default_nettype wire

/* hw/timer_pkg.sv */
`default_nettype none

package timer_pkg;

    typedef logic [31:0] word_t;
    typedef logic [15:0] div_t;  // Prescaler count

    // Request from bus master
    typedef struct packed {
        logic  read;
        logic  write;
        logic  address;  // 0 timer, 1 cycles or divisor
        word_t data_wr;
    } bus_req_t;

    typedef struct packed {
        word_t data_rd;
        logic  stall;
    } bus_rsp_t;

    typedef enum logic {
        cmd_load_timer  = 1'b0,
        cmd_set_divisor = 1'b1
    } cmd_kind_t;

    // Command word sent to the timer domain
    typedef struct packed {
        cmd_kind_t kind;
        word_t     value;
    } timer_cmd_t;

    // 10 MHz / (9 + 1) gives a 1 MHz tick
    localparam div_t DIV_RESET = 16'd9;

    localparam logic ADDR_TIMER  = 1'b0;
    localparam logic ADDR_CYCLES = 1'b1;

endpackage

`default_nettype wire

/* hw/timer_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module timer_subsystem import timer_pkg::*; (
    input  wire            clk_bus,
    input  wire            clk_10M,
    input  wire            rst,
    input  wire bus_req_t  bus_req,
    output bus_rsp_t       bus_rsp
);

    // Bus domain
    timer_cmd_t cmd;
    logic       cmd_valid;
    logic       cmd_busy;
    word_t      snap_data;
    logic       snap_valid;

    // Timer domain
    timer_cmd_t core_cmd;
    logic       core_cmd_valid;
    word_t      timer_value;

    timer_bus_fsm i_bus_fsm (
        .clk_bus    (clk_bus),
        .rst        (rst),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_busy   (cmd_busy),
        .snap_data  (snap_data),
        .snap_valid (snap_valid)
    );

    cdc_handshake #(.payload_t(timer_cmd_t)) i_cmd_xfer (
        .clk_src   (clk_bus),
        .rst       (rst),
        .in_data   (cmd),
        .in_valid  (cmd_valid),
        .busy      (cmd_busy),
        .clk_dst   (clk_10M),
        .out_data  (core_cmd),
        .out_valid (core_cmd_valid)
    );

    timer_core i_core (
        .clk_10M     (clk_10M),
        .rst         (rst),
        .cmd         (core_cmd),
        .cmd_valid   (core_cmd_valid),
        .timer_value (timer_value)
    );

    // Free-running snapshot, restarts as soon as the last one completes
    cdc_handshake #(.payload_t(word_t)) i_snap_xfer (
        .clk_src   (clk_10M),
        .rst       (rst),
        .in_data   (timer_value),
        .in_valid  (1'b1),
        .busy      (),
        .clk_dst   (clk_bus),
        .out_data  (snap_data),
        .out_valid (snap_valid)
    );

endmodule

`default_nettype wire

/* tests/tb_timer_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_timer_subsystem import timer_pkg::*; ();

    localparam int     BUS_HALF      = 15;
    localparam int     TEN_HALF      = 50;
    localparam int     RESET_CYCLES  = 10;
    localparam int     LOAD_TESTS    = 3;
    localparam int     CYCLE_GAP     = 37;
    localparam int     SETTLE_CYCLES = 20;     // Two snapshot rounds of clk_10M cycles
    localparam int     STALL_BOUND   = 40;     // clk_bus cycles per command round trip
    localparam int     MEASURE_NS    = 20000;
    localparam int     TEST_CYCLES   = 800;    // clk_10M cycles for the whole sequence
    localparam longint WATCHDOG_NS   = 40 * TEST_CYCLES * 2 * TEN_HALF;

    logic     clk_bus;
    logic     clk_10M;
    logic     rst;
    bus_req_t bus_req;
    bus_rsp_t bus_rsp;

    time last_accept;
    time release_time;
    int  stall_run;

    timer_subsystem i_dut (
        .clk_bus (clk_bus),
        .clk_10M (clk_10M),
        .rst     (rst),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    initial begin
        clk_10M = 1'b0;
        forever #(TEN_HALF) clk_10M = ~clk_10M;
    end

    initial begin
        clk_bus = 1'b0;
        forever #(BUS_HALF) clk_bus = ~clk_bus;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input word_t expected, input word_t actual);
        assert (actual == expected)
            else fail_run($sformatf("Mismatch %s: expected 0x%08h, got 0x%08h",
                                    name, expected, actual));
    endtask

    task automatic check_range(input string name, input word_t lo, input word_t hi,
                               input word_t actual);
        assert (actual >= lo && actual <= hi)
            else fail_run($sformatf("Mismatch %s: expected 0x%08h to 0x%08h, got 0x%08h",
                                    name, lo, hi, actual));
    endtask

    // Held until stall is seen low and accepted on the following edge
    task automatic bus_write(input logic addr, input word_t data, output int unsigned held);
        logic taken;
        held = 0;
        @(posedge clk_bus);
        #5;
        bus_req.read    = 1'b0;
        bus_req.write   = 1'b1;
        bus_req.address = addr;
        bus_req.data_wr = data;
        taken = !bus_rsp.stall;  // stall only moves on clk_bus edges
        while (!taken) begin
            @(posedge clk_bus);
            #5;
            held++;
            taken = !bus_rsp.stall;
        end
        @(posedge clk_bus);
        last_accept = $time;
        #5;
        bus_req.write = 1'b0;
    endtask

    // Read stays high until the next write
    task automatic bus_read(input logic addr, output word_t value);
        @(posedge clk_bus);
        #5;
        bus_req.write   = 1'b0;
        bus_req.read    = 1'b1;
        bus_req.address = addr;
        #10;
        value = bus_rsp.data_rd;
    endtask

    task automatic wait_idle();
        @(posedge clk_bus);
        #5;
        while (bus_rsp.stall) begin
            @(posedge clk_bus);
            #5;
        end
    endtask

    // Polls every bus cycle so the stamp sits right at a snapshot update
    task automatic wait_snapshot_update(output word_t value, output time stamp);
        word_t first;
        bus_read(ADDR_TIMER, first);
        value = first;
        while (value == first) begin
            bus_read(ADDR_TIMER, value);
        end
        stamp = $time;
    endtask

    task automatic measure_rate(input div_t divisor);
        int unsigned held;
        word_t       t0;
        word_t       t1;
        time         stamp0;
        time         stamp1;
        longint      expected;
        longint      error;
        bus_write(ADDR_CYCLES, word_t'(divisor), held);
        wait_idle();
        bus_write(ADDR_TIMER, 32'd0, held);
        wait_idle();
        repeat (SETTLE_CYCLES) @(posedge clk_10M);
        wait_snapshot_update(t0, stamp0);
        #(MEASURE_NS);
        wait_snapshot_update(t1, stamp1);
        expected = longint'(stamp1 - stamp0) / (2 * TEN_HALF * (longint'(divisor) + 1));
        error = longint'(t1 - t0) - expected;
        assert (error >= -2 && error <= 2)
            else fail_run($sformatf("Mismatch timer delta: expected 0x%0h, got 0x%08h",
                                    expected, t1 - t0));
    endtask

    always @(negedge clk_bus) begin
        if (rst || !bus_rsp.stall) begin
            stall_run = 0;
        end else begin
            stall_run = stall_run + 1;
        end
        assert (stall_run <= STALL_BOUND)
            else fail_run("stall stayed high past the handshake bound, command crossing lost");
    end

    // Negedge sits 10 ns after the inputs settle
    a_rd_zero: assert property (@(negedge clk_bus) disable iff (rst)
        !bus_req.read |-> bus_rsp.data_rd == '0)
        else fail_run($sformatf("Mismatch data_rd: expected 0x00000000, got 0x%08h",
                                bus_rsp.data_rd));

    initial begin
        #(WATCHDOG_NS);
        fail_run("Watchdog expired before the test sequence finished");
    end

    initial begin
        int unsigned held;
        word_t       value;
        word_t       prev;
        word_t       load_value;
        word_t       first_value;
        void'($urandom(32'h6ebf));
        rst = 1'b1;
        bus_req = '0;
        repeat (RESET_CYCLES) @(posedge clk_10M);
        @(posedge clk_bus);
        #5;
        rst = 1'b0;
        release_time = $time;

        // Reset state
        assert (!bus_rsp.stall) else fail_run("stall was high right after reset");
        #3000;
        bus_read(ADDR_TIMER, value);
        check_range("data_rd", 32'd0, word_t'(($time - release_time) / 1000 + 1), value);

        // Cycle counter over CYCLE_GAP bus edges
        bus_read(ADDR_CYCLES, prev);
        repeat (CYCLE_GAP - 1) @(posedge clk_bus);
        bus_read(ADDR_CYCLES, value);
        check_equal("data_rd", prev + word_t'(CYCLE_GAP), value);

        repeat (LOAD_TESTS) begin
            load_value = $urandom & 32'h7fff_ffff;  // No wrap during the check
            bus_write(ADDR_TIMER, load_value, held);
            wait_idle();
            repeat (SETTLE_CYCLES) @(posedge clk_10M);
            bus_read(ADDR_TIMER, value);
            check_range("data_rd", load_value,
                        load_value + word_t'(($time - last_accept) / 1000 + 1), value);
        end

        measure_rate(16'd0);
        measure_rate(16'd3);

        // Back to 1 MHz before the back-pressure case
        bus_write(ADDR_CYCLES, word_t'(DIV_RESET), held);
        wait_idle();
        first_value = 32'h8000_0000 | $urandom;
        load_value = $urandom & 32'h7fff_ffff;
        bus_write(ADDR_TIMER, first_value, held);
        bus_write(ADDR_TIMER, load_value, held);  // Issued while stall is high
        assert (held > 0) else fail_run("second write was not held behind stall");
        wait_idle();
        repeat (SETTLE_CYCLES) @(posedge clk_10M);
        bus_read(ADDR_TIMER, value);
        check_range("data_rd", load_value,
                    load_value + word_t'(($time - last_accept) / 1000 + 1), value);

        @(posedge clk_bus);
        #5;
        bus_req = '0;
        repeat (4) @(posedge clk_bus);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

/* timer_subsystem.f */
hw/timer_pkg.sv
hw/cdc_handshake.sv
hw/timer_bus_fsm.sv
hw/timer_core.sv
hw/timer_subsystem.sv
tests/tb_timer_subsystem.sv
